//--- hw/axil_pkg.sv
// AXI4-Lite write-channel widths, payload structs and response codes
`default_nettype none

package axil_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  // Write address channel, awprot fixed to zero at the slave
  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
  } axil_aw_t;

  // Write data channel, strobes always all ones
  typedef struct packed {
    logic [DATA_W-1:0] wdata;
  } axil_w_t;

  //////////////////////////////////////////////////
  // Response codes
  //////////////////////////////////////////////////

  // Bit 1 set means the write failed
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

endpackage : axil_pkg

`default_nettype wire

//--- hw/dma_cfg_pkg.sv
// MM2S DMA register map, command table constants, frame size and FSM states
`default_nettype none

package dma_cfg_pkg;

  import axil_pkg::*;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  // DMA register block in the AXI-Lite address map
  localparam logic [31:0] DMA_BASE        = 32'h4040_0000;

  // MM2S control register
  localparam logic [31:0] REG_MM2S_DMACR  = 32'h0000_0000;
  // MM2S source address, low word
  localparam logic [31:0] REG_MM2S_SA     = 32'h0000_0018;
  // MM2S transfer length, write starts the transfer
  localparam logic [31:0] REG_MM2S_LENGTH = 32'h0000_0028;

  //////////////////////////////////////////////////
  // Command data
  //////////////////////////////////////////////////

  // RS in bit 0, IOC_IrqEn in bit 12
  localparam logic [31:0] DMACR_RUN_IRQ   = 32'h0000_1001;
  // Frame buffer in DDR
  localparam logic [31:0] FRAME_BUF_ADDR  = 32'h1000_0000;
  // Bytes per frame
  localparam logic [31:0] FRAME_BYTES     = 32'h0000_4000;

  // Three writes per run
  localparam int unsigned NUM_CMDS = 3;
  localparam int unsigned STEP_W   = 2;

  // Stream tlast count at end of frame
  localparam logic [15:0] FRAME_TLAST_COUNT = 16'd8;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // One register write, aw in the upper half
  typedef struct packed {
    axil_aw_t aw;
    axil_w_t  w;
  } dma_cmd_t;

  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    ISSUE      = 2'd1,
    WAIT_RESP  = 2'd2,
    WAIT_FRAME = 2'd3
  } prog_state_e;

endpackage : dma_cfg_pkg

`default_nettype wire

//--- hw/axil_hold_reg.sv
// Valid/ready holding register for one AXI channel payload
`default_nettype none
`timescale 1ns/1ps

module axil_hold_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     m_axi_aclk,
  input  logic     m_axi_aresetn,
  // Load side
  input  logic     i_load,
  input  payload_t i_payload,
  // Channel side
  output payload_t o_payload,
  output logic     o_valid,
  input  logic     i_ready
);

  logic handshake;

  // Beat accepted by the slave this cycle
  assign handshake = o_valid & i_ready;

  // Valid flag, the only control state here
  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      o_valid <= 1'b0;
    end else if (i_load) begin
      o_valid <= 1'b1;
    end else if (handshake) begin
      // Drops on the cycle after the handshake
      o_valid <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge m_axi_aclk) begin
    if (i_load) begin
      o_payload <= i_payload;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Slave stalls, payload must not move
  a_hold_stable : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_payload))
  );

  // Upstream waits for the response, so a load never overlaps a pending beat
  a_no_load_busy : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    i_load |-> !o_valid
  );

endmodule : axil_hold_reg

`default_nettype wire

//--- hw/dma_cmd_table.sv
// Register-write command table for DMA programming, indexed by step
`default_nettype none
`timescale 1ns/1ps

module dma_cmd_table
  import axil_pkg::*, dma_cfg_pkg::*;
(
  input  logic [STEP_W-1:0] i_step,
  output dma_cmd_t          o_cmd
);

  // Step order: control, source address, length
  // Length goes last since that write kicks off the transfer
  always_comb begin
    case (i_step)
      2'd0: begin
        // Run plus completion interrupt
        o_cmd.aw = axil_aw_t'(DMA_BASE + REG_MM2S_DMACR);
        o_cmd.w  = axil_w_t'(DMACR_RUN_IRQ);
      end
      2'd1: begin
        // Frame buffer start
        o_cmd.aw = axil_aw_t'(DMA_BASE + REG_MM2S_SA);
        o_cmd.w  = axil_w_t'(FRAME_BUF_ADDR);
      end
      2'd2: begin
        // Byte count
        o_cmd.aw = axil_aw_t'(DMA_BASE + REG_MM2S_LENGTH);
        o_cmd.w  = axil_w_t'(FRAME_BYTES);
      end
      default: begin
        // Unused step, never loaded
        o_cmd.aw = axil_aw_t'('0);
        o_cmd.w  = axil_w_t'('0);
      end
    endcase
  end

endmodule : dma_cmd_table

`default_nettype wire

//--- hw/dma_step_counter.sv
// Command step counter advanced by accepted write responses
`default_nettype none
`timescale 1ns/1ps

module dma_step_counter
  import dma_cfg_pkg::*;
(
  input  logic              m_axi_aclk,
  input  logic              m_axi_aresetn,
  // Run control
  input  logic              i_clear,
  input  logic              i_resp_fire,
  // Step index to the table
  output logic [STEP_W-1:0] o_step,
  output logic              o_last_step
);

  // High on the final table entry
  assign o_last_step = (o_step == STEP_W'(NUM_CMDS - 1));

  //////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      o_step <= '0;
    end else if (i_clear) begin
      // New run restarts the table
      o_step <= '0;
    end else if (i_resp_fire && !o_last_step) begin
      o_step <= o_step + 1'b1;
    end
    // Last response leaves the index parked until the next clear
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Clear wins over a response, so the two never share a cycle
  a_resp_not_on_clear : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    i_resp_fire |-> !i_clear
  );

endmodule : dma_step_counter

`default_nettype wire

//--- hw/dma_prog_fsm.sv
// Start synchronizers, edge detect, run FSM, sticky error flag and done interrupt
`default_nettype none
`timescale 1ns/1ps

module dma_prog_fsm
  import axil_pkg::*, dma_cfg_pkg::*;
(
  input  logic        m_axi_aclk,
  input  logic        m_axi_aresetn,
  // Asynchronous start levels
  input  logic        i_frame_start,
  input  logic        i_start_input_gpio,
  // Write response
  input  logic        i_resp_fire,
  input  axil_resp_e  i_resp,
  input  logic        i_last_step,
  // Stream side tlast count
  input  logic [15:0] i_tlast_cnt,
  // To step counter and hold registers
  output logic        o_clear,
  output logic        o_load,
  // Status
  output logic        o_dma_done_irq,
  output logic        o_write_error
);

  // Bit 0 frame start, bit 1 gpio start
  // Stages 0 and 1 synchronize, stage 2 holds the previous level
  logic [2:0][1:0] start_pipe;
  logic [1:0]      start_rise;
  logic            start_edge;

  prog_state_e state_q;
  prog_state_e state_d;

  //////////////////////////////////////////////////
  // Start synchronizers and edge detect
  //////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      start_pipe <= '0;
    end else begin
      start_pipe <= {start_pipe[1:0], {i_start_input_gpio, i_frame_start}};
    end
  end

  assign start_rise = start_pipe[1] & ~start_pipe[2];
  // Either source launches a run
  assign start_edge = |start_rise;

  //////////////////////////////////////////////////
  // Run FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Edges outside IDLE are dropped
      IDLE:       if (start_edge) state_d = ISSUE;
      // One cycle in which the hold registers load
      ISSUE:      state_d = WAIT_RESP;
      WAIT_RESP: begin
        if (i_resp_fire) begin
          state_d = i_last_step ? WAIT_FRAME : ISSUE;
        end
      end
      WAIT_FRAME: if (i_tlast_cnt == FRAME_TLAST_COUNT) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  // Step counter restarts as the run leaves IDLE
  assign o_clear = (state_q == IDLE) && start_edge;

  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      state_q        <= IDLE;
      o_load         <= 1'b0;
      o_dma_done_irq <= 1'b0;
      o_write_error  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Registered, so it lines up with the first ISSUE cycle
      o_load  <= (state_d == ISSUE);
      // Single pulse as WAIT_FRAME exits on the matching count
      o_dma_done_irq <= (state_q == WAIT_FRAME) && (i_tlast_cnt == FRAME_TLAST_COUNT);
      // Sticky error until the next start clears it
      if (o_clear) begin
        o_write_error <= 1'b0;
      end else if (i_resp_fire && (i_resp inside {SLVERR, DECERR})) begin
        o_write_error <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Only one write in flight, so its response arrives in WAIT_RESP
  a_resp_in_wait : assert property (
    @(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    i_resp_fire |-> (state_q == WAIT_RESP)
  );

endmodule : dma_prog_fsm

`default_nettype wire

//--- hw/dma_axil_master.sv
// AXI4-Lite write master top level for MM2S DMA programming
`default_nettype none
`timescale 1ns/1ps

module dma_axil_master
  import axil_pkg::*, dma_cfg_pkg::*;
(
  input  logic              m_axi_aclk,
  input  logic              m_axi_aresetn,
  // Write address channel
  output logic [ADDR_W-1:0] o_m_axi_awaddr,
  output logic              o_m_axi_awvalid,
  input  logic              i_m_axi_awready,
  // Write data channel
  output logic [DATA_W-1:0] o_m_axi_wdata,
  output logic              o_m_axi_wvalid,
  input  logic              i_m_axi_wready,
  // Write response channel
  input  logic [1:0]        i_m_axi_bresp,
  input  logic              i_m_axi_bvalid,
  output logic              o_m_axi_bready,
  // Run control and status
  input  logic              i_frame_start,
  input  logic              i_start_input_gpio,
  input  logic [15:0]       i_cnt_m_axis_mm2s_tlast_pos,
  output logic              o_dma_done_irq,
  output logic              o_write_error
);

  logic              clear;
  logic              load;
  logic              resp_fire;
  logic              last_step;
  logic [STEP_W-1:0] step;
  dma_cmd_t          cmd;
  axil_aw_t          aw_q;
  axil_w_t           w_q;

  //////////////////////////////////////////////////
  // Write response channel
  //////////////////////////////////////////////////

  // Responses always accepted once out of reset
  always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn) begin
    if (!m_axi_aresetn) begin
      o_m_axi_bready <= 1'b0;
    end else begin
      o_m_axi_bready <= 1'b1;
    end
  end

  assign resp_fire = o_m_axi_bready & i_m_axi_bvalid;

  // Sequencing
  dma_prog_fsm fsm_i (
    .m_axi_aclk         (m_axi_aclk),
    .m_axi_aresetn      (m_axi_aresetn),
    .i_frame_start      (i_frame_start),
    .i_start_input_gpio (i_start_input_gpio),
    .i_resp_fire        (resp_fire),
    .i_resp             (axil_resp_e'(i_m_axi_bresp)),
    .i_last_step        (last_step),
    .i_tlast_cnt        (i_cnt_m_axis_mm2s_tlast_pos),
    .o_clear            (clear),
    .o_load             (load),
    .o_dma_done_irq     (o_dma_done_irq),
    .o_write_error      (o_write_error)
  );

  dma_step_counter step_i (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .i_clear       (clear),
    .i_resp_fire   (resp_fire),
    .o_step        (step),
    .o_last_step   (last_step)
  );

  dma_cmd_table table_i (
    .i_step (step),
    .o_cmd  (cmd)
  );

  //////////////////////////////////////////////////
  // AW and W channel sources
  //////////////////////////////////////////////////

  axil_hold_reg #(.payload_t(axil_aw_t)) aw_hold (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .i_load        (load),
    .i_payload     (cmd.aw),
    .o_payload     (aw_q),
    .o_valid       (o_m_axi_awvalid),
    .i_ready       (i_m_axi_awready)
  );

  axil_hold_reg #(.payload_t(axil_w_t)) w_hold (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .i_load        (load),
    .i_payload     (cmd.w),
    .o_payload     (w_q),
    .o_valid       (o_m_axi_wvalid),
    .i_ready       (i_m_axi_wready)
  );

  assign o_m_axi_awaddr = aw_q.awaddr;
  assign o_m_axi_wdata  = w_q.wdata;

endmodule : dma_axil_master

`default_nettype wire

//--- bench/tb_checks.svh
// Expected-write queues, error counters, compare tasks and closing count line
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned mismatch_cnt = 0;
int unsigned other_cnt    = 0;

// Writes still owed by the DUT, in bus order
axil_aw_t exp_aw_q[$];
axil_w_t  exp_w_q[$];

// One run: control, then source address, then length
task automatic push_run_writes();
  exp_aw_q.push_back(axil_aw_t'(DMA_BASE + REG_MM2S_DMACR));
  exp_w_q.push_back(axil_w_t'(DMACR_RUN_IRQ));
  exp_aw_q.push_back(axil_aw_t'(DMA_BASE + REG_MM2S_SA));
  exp_w_q.push_back(axil_w_t'(FRAME_BUF_ADDR));
  exp_aw_q.push_back(axil_aw_t'(DMA_BASE + REG_MM2S_LENGTH));
  exp_w_q.push_back(axil_w_t'(FRAME_BYTES));
endtask

task automatic compare_aw(input string name, input axil_aw_t exp, input axil_aw_t act);
  if (act !== exp) begin
    mismatch_cnt++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp.awaddr, act.awaddr);
  end
endtask

task automatic compare_w(input string name, input axil_w_t exp, input axil_w_t act);
  if (act !== exp) begin
    mismatch_cnt++;
    $display("MISMATCH %s: expected %h, actual %h", name, exp.wdata, act.wdata);
  end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    mismatch_cnt++;
    $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic report_failure(input string what);
  other_cnt++;
  $display("ERROR %s", what);
endtask

task automatic print_counts(input int writes, input int errs);
  $display("errors: %0d mismatches, %0d other, %0d writes seen, %0d error responses",
           mismatch_cnt, other_cnt, writes, errs);
endtask

`endif

//--- bench/tb_dma_axil_master.sv
// DMA AXI-Lite master testbench with clock, reset, LFSR, AXI slave responder, tlast ramp and runs
`default_nettype none
`timescale 1ns/1ps

module tb_dma_axil_master
  import axil_pkg::*, dma_cfg_pkg::*;
();

  localparam int NUM_RUNS   = 12;
  localparam int RST_CYCLES = 8;
  // Worst run is gap, sync, three stalled writes, ramp delay and slow ramp
  localparam int RUN_MAX    = 16 + int'(NUM_CMDS) * 48 + 8 + 4 * (int'(FRAME_TLAST_COUNT) + 3);
  localparam int TIMEOUT    = NUM_RUNS * RUN_MAX * 2;

  logic              m_axi_aclk    = 1'b0;
  logic              m_axi_aresetn = 1'b0;
  logic [ADDR_W-1:0] o_m_axi_awaddr;
  logic              o_m_axi_awvalid;
  logic              i_m_axi_awready = 1'b0;
  logic [DATA_W-1:0] o_m_axi_wdata;
  logic              o_m_axi_wvalid;
  logic              i_m_axi_wready = 1'b0;
  logic [1:0]        i_m_axi_bresp  = 2'b00;
  logic              i_m_axi_bvalid = 1'b0;
  logic              o_m_axi_bready;
  logic              i_frame_start      = 1'b0;
  logic              i_start_input_gpio = 1'b0;
  logic [15:0]       i_cnt_m_axis_mm2s_tlast_pos = 16'd0;
  logic              o_dma_done_irq;
  logic              o_write_error;

  // Sequencer to responder handoff
  int   cyc       = 0;
  int   launch_at = -100;
  int   irq_cnt   = 0;
  logic checks_on = 1'b0;
  logic stim_done = 1'b0;

  // Slave and reference model state
  logic        aw_seen    = 1'b0;
  logic        w_seen     = 1'b0;
  logic        b_busy     = 1'b0;
  logic        aw_stall   = 1'b0;
  logic        w_stall    = 1'b0;
  logic        frame_wait = 1'b0;
  logic        ramping    = 1'b0;
  logic        exp_irq    = 1'b0;
  logic        exp_err    = 1'b0;
  axil_aw_t    aw_held;
  axil_w_t     w_held;
  int          b_delay     = 0;
  int          ramp_delay  = 0;
  int          wr_in_run   = 0;
  int          write_total = 0;
  int          err_total   = 0;
  logic [31:0] lfsr_q = 32'hb582_ee58;

  `include "tb_checks.svh"

  always #20 m_axi_aclk = ~m_axi_aclk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  dma_axil_master dut_i (
    .m_axi_aclk                  (m_axi_aclk),
    .m_axi_aresetn               (m_axi_aresetn),
    .o_m_axi_awaddr              (o_m_axi_awaddr),
    .o_m_axi_awvalid             (o_m_axi_awvalid),
    .i_m_axi_awready             (i_m_axi_awready),
    .o_m_axi_wdata               (o_m_axi_wdata),
    .o_m_axi_wvalid              (o_m_axi_wvalid),
    .i_m_axi_wready              (i_m_axi_wready),
    .i_m_axi_bresp               (i_m_axi_bresp),
    .i_m_axi_bvalid              (i_m_axi_bvalid),
    .o_m_axi_bready              (o_m_axi_bready),
    .i_frame_start               (i_frame_start),
    .i_start_input_gpio          (i_start_input_gpio),
    .i_cnt_m_axis_mm2s_tlast_pos (i_cnt_m_axis_mm2s_tlast_pos),
    .o_dma_done_irq              (o_dma_done_irq),
    .o_write_error               (o_write_error)
  );

  //////////////////////////////////////////////////
  // Slave responder, tlast ramp and model
  //////////////////////////////////////////////////

  always @(posedge m_axi_aclk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      report_failure($sformatf("timeout after %0d cycles with %0d runs done", cyc, irq_cnt));
      print_counts(write_total, err_total);
      $display("sim failed");
      $finish;
    end else if (stim_done) begin
      if (exp_aw_q.size() != 0 || exp_w_q.size() != 0) begin
        report_failure("expected register writes were never issued");
      end
      if (irq_cnt != NUM_RUNS) begin
        report_failure($sformatf("%0d done interrupts for %0d runs", irq_cnt, NUM_RUNS));
      end
      print_counts(write_total, err_total);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end else if (checks_on) begin
      // Pre-edge outputs against the model
      compare_flag("bready", 1'b1, o_m_axi_bready);
      compare_flag("write_error", exp_err, o_write_error);
      compare_flag("done_irq", exp_irq, o_dma_done_irq);
      if (o_dma_done_irq) begin
        irq_cnt <= irq_cnt + 1;
      end
      // Interrupt due one cycle after the first matching count
      exp_irq = frame_wait && (i_cnt_m_axis_mm2s_tlast_pos == FRAME_TLAST_COUNT);
      if (exp_irq) begin
        frame_wait = 1'b0;
      end
      if (cyc == launch_at + 2) begin
        compare_flag("awvalid after start", 1'b1, o_m_axi_awvalid);
        compare_flag("wvalid after start", 1'b1, o_m_axi_wvalid);
      end
      // FSM leaves IDLE here
      if (cyc == launch_at) begin
        push_run_writes();
        exp_err = 1'b0;
        wr_in_run = 0;
        ramping = 1'b0;
        i_cnt_m_axis_mm2s_tlast_pos <= 16'd0;
      end
      if (i_m_axi_bvalid && o_m_axi_bready) begin
        i_m_axi_bvalid <= 1'b0;
        aw_seen = 1'b0;
        w_seen = 1'b0;
        b_busy = 1'b0;
        write_total++;
        wr_in_run++;
        if (i_m_axi_bresp[1]) begin
          exp_err = 1'b1;
          err_total++;
        end
        if (wr_in_run == int'(NUM_CMDS)) begin
          frame_wait = 1'b1;
          ramping = 1'b1;
          ramp_delay = int'(rand_bits(3));
        end
      end
      // Stalled beats must keep valid and payload
      if (aw_stall) begin
        compare_flag("awvalid hold", 1'b1, o_m_axi_awvalid);
        compare_aw("aw hold", aw_held, axil_aw_t'(o_m_axi_awaddr));
      end
      if (w_stall) begin
        compare_flag("wvalid hold", 1'b1, o_m_axi_wvalid);
        compare_w("w hold", w_held, axil_w_t'(o_m_axi_wdata));
      end
      aw_stall = o_m_axi_awvalid && !i_m_axi_awready;
      w_stall = o_m_axi_wvalid && !i_m_axi_wready;
      aw_held = axil_aw_t'(o_m_axi_awaddr);
      w_held = axil_w_t'(o_m_axi_wdata);
      if (o_m_axi_awvalid && i_m_axi_awready) begin
        if (aw_seen) begin
          report_failure("AW accepted while the previous write was unanswered");
        end
        aw_seen = 1'b1;
        if (exp_aw_q.size() == 0) begin
          report_failure("AW accepted with no write expected");
        end else begin
          compare_aw("aw addr", exp_aw_q.pop_front(), axil_aw_t'(o_m_axi_awaddr));
        end
      end
      if (o_m_axi_wvalid && i_m_axi_wready) begin
        if (w_seen) begin
          report_failure("W accepted while the previous write was unanswered");
        end
        w_seen = 1'b1;
        if (exp_w_q.size() == 0) begin
          report_failure("W accepted with no write expected");
        end else begin
          compare_w("w data", exp_w_q.pop_front(), axil_w_t'(o_m_axi_wdata));
        end
      end
      // Response after a random delay with SLVERR about one in eight
      if (aw_seen && w_seen && !b_busy) begin
        b_busy = 1'b1;
        b_delay = int'(rand_bits(3));
      end
      if (b_busy && !i_m_axi_bvalid) begin
        if (b_delay == 0) begin
          i_m_axi_bvalid <= 1'b1;
          i_m_axi_bresp <= (rand_bits(3) == 32'd0) ? SLVERR : OKAY;
        end else begin
          b_delay--;
        end
      end
      // Ramp runs past the frame count, then holds
      if (ramping) begin
        if (ramp_delay > 0) begin
          ramp_delay--;
        end else if (i_cnt_m_axis_mm2s_tlast_pos < FRAME_TLAST_COUNT + 16'd3 && rand_bit()) begin
          i_cnt_m_axis_mm2s_tlast_pos <= i_cnt_m_axis_mm2s_tlast_pos + 16'd1;
        end
      end
      i_m_axi_awready <= rand_bit();
      i_m_axi_wready <= rand_bit();
    end
  end

  //////////////////////////////////////////////////
  // Run sequence
  //////////////////////////////////////////////////

  task automatic pulse_start(input logic use_gpio);
    if (use_gpio) begin
      i_start_input_gpio <= 1'b1;
    end else begin
      i_frame_start <= 1'b1;
    end
    repeat (2) @(posedge m_axi_aclk);
    i_start_input_gpio <= 1'b0;
    i_frame_start <= 1'b0;
  endtask

  initial begin
    repeat (RST_CYCLES) @(posedge m_axi_aclk);
    m_axi_aresetn <= 1'b1;
    repeat (2) @(posedge m_axi_aclk);
    checks_on <= 1'b1;
    for (int r = 0; r < NUM_RUNS; r++) begin
      repeat (3 + r % 4) @(posedge m_axi_aclk);
      // Two sync flops plus edge flop
      launch_at <= cyc + 3;
      pulse_start(r % 2 == 1);
      // Spurious edge mid-run from the other source or the same one
      if (r % 3 != 0) begin
        repeat (4) @(posedge m_axi_aclk);
        pulse_start((r % 3 == 1) ? (r % 2 == 0) : (r % 2 == 1));
      end
      while (irq_cnt <= r) begin
        @(posedge m_axi_aclk);
      end
    end
    repeat (10) @(posedge m_axi_aclk);
    stim_done <= 1'b1;
  end

endmodule : tb_dma_axil_master

`default_nettype wire

//--- tb.f
+incdir+bench
hw/axil_pkg.sv
hw/dma_cfg_pkg.sv
hw/axil_hold_reg.sv
hw/dma_cmd_table.sv
hw/dma_step_counter.sv
hw/dma_prog_fsm.sv
hw/dma_axil_master.sv
bench/tb_dma_axil_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA AXI-Lite master testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module tb_dma_axil_master -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "^sim passed$" sim.log; then
  exit 0
else
  exit 1
fi
